// ==== verilog/regexec_pkg.sv ====
package regexec_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	localparam int XLEN    = 32;
	localparam int NREGS   = 32;
	localparam int RADDR_W = 5;

	//////////////////////////////////////////////////////////////////////
	// Instruction word, R and I views of the same 32 bits
	//////////////////////////////////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r_fmt;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i_fmt;
	} instr_t;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;

	// Function codes for OP_RTYPE
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_NOR = 6'h27;
	localparam logic [5:0] FN_SLT = 6'h2a;

	//////////////////////////////////////////////////////////////////////
	// ALU operations
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_t;

endpackage

// ==== verilog/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode
(
	input  logic                            clk,
	input  logic                            rst,
	input  regexec_pkg::instr_t             instr,
	input  logic                            instr_valid,
	output logic [regexec_pkg::RADDR_W-1:0] rs_addr,
	output logic [regexec_pkg::RADDR_W-1:0] rt_addr,
	output logic                            dec_valid,
	output logic                            dec_illegal,
	output regexec_pkg::alu_op_t            dec_op,
	output logic [regexec_pkg::RADDR_W-1:0] dec_dest,
	output logic [regexec_pkg::XLEN-1:0]    dec_imm,
	output logic                            dec_use_imm,
	output logic [regexec_pkg::RADDR_W-1:0] dec_shamt
);
	import regexec_pkg::*;

	alu_op_t            op_nxt;
	logic [RADDR_W-1:0] dest_nxt;
	logic [XLEN-1:0]    imm_nxt;
	logic               use_imm_nxt;
	logic               legal;
	logic [XLEN-1:0]    imm_sext;
	logic [XLEN-1:0]    imm_zext;

	// rs and rt sit in the same bits in both formats
	assign rs_addr = instr.i_fmt.rs;
	assign rt_addr = instr.i_fmt.rt;

	assign imm_sext = {{(XLEN-16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
	assign imm_zext = {{(XLEN-16){1'b0}}, instr.i_fmt.imm};

	//////////////////////////////////////////////////////////////////////
	// Opcode and function decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		op_nxt      = ALU_ADD;
		dest_nxt    = instr.i_fmt.rt;
		imm_nxt     = imm_zext;
		use_imm_nxt = 1'b1;
		legal       = 1'b1;
		case (instr.r_fmt.opcode)
			OP_RTYPE:
			begin
				dest_nxt    = instr.r_fmt.rd;
				use_imm_nxt = 1'b0;
				case (instr.r_fmt.funct)
					FN_ADD:  op_nxt = ALU_ADD;
					FN_SUB:  op_nxt = ALU_SUB;
					FN_AND:  op_nxt = ALU_AND;
					FN_OR:   op_nxt = ALU_OR;
					FN_XOR:  op_nxt = ALU_XOR;
					FN_NOR:  op_nxt = ALU_NOR;
					FN_SLT:  op_nxt = ALU_SLT;
					FN_SLL:  op_nxt = ALU_SLL;
					FN_SRL:  op_nxt = ALU_SRL;
					default: legal = 1'b0;
				endcase
			end
			// Arithmetic immediates are sign extended
			OP_ADDI:
			begin
				op_nxt  = ALU_ADD;
				imm_nxt = imm_sext;
			end
			OP_SLTI:
			begin
				op_nxt  = ALU_SLT;
				imm_nxt = imm_sext;
			end
			OP_ANDI: op_nxt = ALU_AND;
			OP_ORI:  op_nxt = ALU_OR;
			OP_XORI: op_nxt = ALU_XOR;
			OP_LUI:  op_nxt = ALU_LUI;
			default: legal = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Decode register, aligned with the bank read
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dec_valid   <= 1'b0;
			dec_illegal <= 1'b0;
		end
		else
		begin
			dec_valid   <= instr_valid & legal;
			dec_illegal <= instr_valid & ~legal;
		end
	end

	always_ff @(posedge clk)
	begin
		dec_op      <= op_nxt;
		dec_dest    <= dest_nxt;
		dec_imm     <= imm_nxt;
		dec_use_imm <= use_imm_nxt;
		dec_shamt   <= instr.r_fmt.shamt;
	end

endmodule

// ==== verilog/reg_bank.sv ====
`timescale 1ns/100ps

module reg_bank
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic [regexec_pkg::RADDR_W-1:0] rs_addr,
	input  logic [regexec_pkg::RADDR_W-1:0] rt_addr,
	input  logic                            wb_en,
	input  logic [regexec_pkg::RADDR_W-1:0] wb_addr,
	input  logic [regexec_pkg::XLEN-1:0]    wb_data,
	input  logic [regexec_pkg::RADDR_W-1:0] dump_addr,
	output logic [regexec_pkg::XLEN-1:0]    rd1,
	output logic [regexec_pkg::XLEN-1:0]    rd2,
	output logic [regexec_pkg::XLEN-1:0]    dump_data
);
	import regexec_pkg::*;

	logic [XLEN-1:0]    regs [NREGS];
	logic [XLEN-1:0]    rd1_q;
	logic [XLEN-1:0]    rd2_q;
	logic [RADDR_W-1:0] rs_q;
	logic [RADDR_W-1:0] rt_q;

	// One read port, register 0 hardwired, same-cycle write passed through
	function automatic logic [XLEN-1:0] read_port(input logic [RADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wb_en && wb_addr == addr)
			return wb_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end
		else if (wb_en && wb_addr != '0)
			regs[wb_addr] <= wb_data;
	end

	always_ff @(posedge clk)
	begin
		rd1_q     <= read_port(rs_addr);
		rd2_q     <= read_port(rt_addr);
		rs_q      <= rs_addr;
		rt_q      <= rt_addr;
		dump_data <= read_port(dump_addr);
	end

	// A result registered alongside the operands is the newest value
	// for that register, so it overrides the stored read
	assign rd1 = (wb_en && wb_addr != '0 && wb_addr == rs_q) ? wb_data : rd1_q;
	assign rd2 = (wb_en && wb_addr != '0 && wb_addr == rt_q) ? wb_data : rd2_q;

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

module alu
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            dec_valid,
	input  logic                            dec_illegal,
	input  regexec_pkg::alu_op_t            dec_op,
	input  logic [regexec_pkg::RADDR_W-1:0] dec_dest,
	input  logic [regexec_pkg::XLEN-1:0]    dec_imm,
	input  logic                            dec_use_imm,
	input  logic [regexec_pkg::RADDR_W-1:0] dec_shamt,
	input  logic [regexec_pkg::XLEN-1:0]    rd1,
	input  logic [regexec_pkg::XLEN-1:0]    rd2,
	output logic                            wb_en,
	output logic [regexec_pkg::RADDR_W-1:0] wb_addr,
	output logic [regexec_pkg::XLEN-1:0]    wb_data,
	output logic                            illegal
);
	import regexec_pkg::*;

	logic [XLEN-1:0] opb;
	logic [XLEN-1:0] result;

	// Second operand
	assign opb = dec_use_imm ? dec_imm : rd2;

	always_comb
	begin
		case (dec_op)
			ALU_ADD: result = rd1 + opb;
			ALU_SUB: result = rd1 - opb;
			ALU_AND: result = rd1 & opb;
			ALU_OR:  result = rd1 | opb;
			ALU_XOR: result = rd1 ^ opb;
			ALU_NOR: result = ~(rd1 | opb);
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(rd1) < $signed(opb)};
			// Shifts act on rt, amount from the shamt field
			ALU_SLL: result = rd2 << dec_shamt;
			ALU_SRL: result = rd2 >> dec_shamt;
			ALU_LUI: result = {dec_imm[XLEN/2-1:0], {(XLEN/2){1'b0}}};
			default: result = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Result register, also the bank write request
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_en   <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			wb_en   <= dec_valid;
			illegal <= dec_illegal;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_addr <= dec_dest;
		wb_data <= result;
	end

endmodule

// ==== verilog/reg_dump.sv ====
`timescale 1ns/100ps

module reg_dump
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            dump_req,
	input  logic [regexec_pkg::XLEN-1:0]    dump_data,
	output logic [regexec_pkg::RADDR_W-1:0] dump_addr,
	output logic                            dump_valid,
	output logic [regexec_pkg::RADDR_W-1:0] dump_index,
	output logic [regexec_pkg::XLEN-1:0]    dump_word
);
	import regexec_pkg::*;

	logic               running;
	logic               rd_pend;
	logic [RADDR_W-1:0] idx_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			running    <= 1'b0;
			dump_addr  <= '0;
			rd_pend    <= 1'b0;
			idx_q      <= '0;
			dump_valid <= 1'b0;
			dump_index <= '0;
		end
		else
		begin
			// Requests while running are dropped
			if (running)
			begin
				dump_addr <= dump_addr + 1'b1;
				if (dump_addr == RADDR_W'(NREGS - 1))
					running <= 1'b0;
			end
			else if (dump_req)
			begin
				running   <= 1'b1;
				dump_addr <= '0;
			end
			// Index follows the bank read, then the output register
			rd_pend    <= running;
			idx_q      <= dump_addr;
			dump_valid <= rd_pend;
			dump_index <= idx_q;
		end
	end

	always_ff @(posedge clk)
	begin
		dump_word <= dump_data;
	end

endmodule

// ==== verilog/regexec_top.sv ====
`timescale 1ns/100ps

module regexec_top
(
	input  logic                            clk,
	input  logic                            rst,
	input  regexec_pkg::instr_t             instr,
	input  logic                            instr_valid,
	input  logic                            dump_req,
	output logic                            result_valid,
	output logic [regexec_pkg::RADDR_W-1:0] result_dest,
	output logic [regexec_pkg::XLEN-1:0]    result_data,
	output logic                            illegal,
	output logic                            dump_valid,
	output logic [regexec_pkg::RADDR_W-1:0] dump_index,
	output logic [regexec_pkg::XLEN-1:0]    dump_word
);
	import regexec_pkg::*;

	// Decode stage
	logic [RADDR_W-1:0] rs_addr;
	logic [RADDR_W-1:0] rt_addr;
	logic               dec_valid;
	logic               dec_illegal;
	alu_op_t            dec_op;
	logic [RADDR_W-1:0] dec_dest;
	logic [XLEN-1:0]    dec_imm;
	logic               dec_use_imm;
	logic [RADDR_W-1:0] dec_shamt;

	// Operands and dump port
	logic [XLEN-1:0]    rd1;
	logic [XLEN-1:0]    rd2;
	logic [RADDR_W-1:0] dump_addr;
	logic [XLEN-1:0]    dump_data;

	instr_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.dec_valid   (dec_valid),
		.dec_illegal (dec_illegal),
		.dec_op      (dec_op),
		.dec_dest    (dec_dest),
		.dec_imm     (dec_imm),
		.dec_use_imm (dec_use_imm),
		.dec_shamt   (dec_shamt)
	);

	// The result outputs double as the write request
	reg_bank u_bank (
		.clk       (clk),
		.rst       (rst),
		.rs_addr   (rs_addr),
		.rt_addr   (rt_addr),
		.wb_en     (result_valid),
		.wb_addr   (result_dest),
		.wb_data   (result_data),
		.dump_addr (dump_addr),
		.rd1       (rd1),
		.rd2       (rd2),
		.dump_data (dump_data)
	);

	alu u_alu (
		.clk         (clk),
		.rst         (rst),
		.dec_valid   (dec_valid),
		.dec_illegal (dec_illegal),
		.dec_op      (dec_op),
		.dec_dest    (dec_dest),
		.dec_imm     (dec_imm),
		.dec_use_imm (dec_use_imm),
		.dec_shamt   (dec_shamt),
		.rd1         (rd1),
		.rd2         (rd2),
		.wb_en       (result_valid),
		.wb_addr     (result_dest),
		.wb_data     (result_data),
		.illegal     (illegal)
	);

	reg_dump u_dump (
		.clk        (clk),
		.rst        (rst),
		.dump_req   (dump_req),
		.dump_data  (dump_data),
		.dump_addr  (dump_addr),
		.dump_valid (dump_valid),
		.dump_index (dump_index),
		.dump_word  (dump_word)
	);

endmodule

// ==== test/regexec_chk.sv ====
`timescale 1ns/100ps

module regexec_chk
(
	input logic                            clk,
	input logic                            rst,
	input logic                            result_valid,
	input logic                            illegal,
	input logic                            dump_valid,
	input logic [regexec_pkg::RADDR_W-1:0] dump_index
);
	import regexec_pkg::*;

	int fail_count = 0;

	// Result and illegal pulses are exclusive
	a_excl: assert property (@(posedge clk) disable iff (rst) !(result_valid && illegal))
	else
	begin
		fail_count++;
		$error("result_valid and illegal are high in the same cycle");
	end

	// Dump index steps by one inside a dump
	a_index: assert property (@(posedge clk) disable iff (rst)
		dump_valid && $past(dump_valid) |-> dump_index == RADDR_W'($past(dump_index) + 1'b1))
	else
	begin
		fail_count++;
		$error("dump_index did not step by one while dump_valid was high");
	end

	a_reset: assert property (@(posedge clk) rst |=> !result_valid && !illegal && !dump_valid)
	else
	begin
		fail_count++;
		$error("An output pulse was high in the cycle after reset");
	end

endmodule

// ==== test/regexec_monitor.sv ====
`timescale 1ns/100ps

module regexec_monitor
(
	input logic                            clk,
	input logic                            rst,
	input logic                            result_valid,
	input logic [regexec_pkg::RADDR_W-1:0] result_dest,
	input logic [regexec_pkg::XLEN-1:0]    result_data,
	input logic                            illegal,
	input logic                            dump_valid,
	input logic [regexec_pkg::RADDR_W-1:0] dump_index,
	input logic [regexec_pkg::XLEN-1:0]    dump_word
);
	import regexec_pkg::*;

	// Each entry is {illegal, dest, value}
	logic [XLEN+RADDR_W:0] expq [$];
	logic [XLEN-1:0]       final_regs [NREGS];
	logic                  exp_ill;
	logic [RADDR_W-1:0]    exp_dest;
	logic [XLEN-1:0]       exp_val;
	int                    pending = 0;
	int                    dump_count = 0;
	int                    mismatches = 0;
	int                    errors = 0;

	initial
	begin
		for (int i = 0; i < NREGS; i++)
			final_regs[i] = '0;
	end

	task automatic queue_result(input logic [XLEN+RADDR_W:0] e);
		logic               ill;
		logic [RADDR_W-1:0] d;
		logic [XLEN-1:0]    v;
		{ill, d, v} = e;
		expq.push_back(e);
		pending++;
		// Bank model, the last write wins and register 0 stays zero
		if (!ill && d != '0)
			final_regs[d] = v;
	endtask

	always @(posedge clk)
	begin
		if (!rst && (result_valid || illegal))
		begin
			if (pending == 0)
			begin
				errors++;
				$display("Output pulse seen with no instruction outstanding");
			end
			else
			begin
				{exp_ill, exp_dest, exp_val} = expq.pop_front();
				pending--;
				if (illegal !== exp_ill)
				begin
					mismatches++;
					$display("[ERROR] illegal: got %h expected %h", illegal, exp_ill);
				end
				else if (!exp_ill && (result_dest !== exp_dest || result_data !== exp_val))
				begin
					mismatches++;
					$display("[ERROR] result_dest/result_data: got %h/%h expected %h/%h",
						result_dest, result_data, exp_dest, exp_val);
				end
			end
		end
		if (!rst && dump_valid)
		begin
			if (dump_count >= NREGS)
			begin
				errors++;
				$display("Dump produced more than %0d words", NREGS);
			end
			else if (dump_index !== RADDR_W'(dump_count) || dump_word !== final_regs[dump_count])
			begin
				mismatches++;
				$display("[ERROR] dump_index/dump_word: got %h/%h expected %h/%h",
					dump_index, dump_word, RADDR_W'(dump_count), final_regs[dump_count]);
			end
			dump_count++;
		end
	end

endmodule

// ==== test/regexec_tb.sv ====
`timescale 1ns/100ps

module regexec_tb;
	import regexec_pkg::*;

	logic               clk;
	logic               rst;
	instr_t             instr;
	logic               instr_valid;
	logic               dump_req;
	logic               result_valid;
	logic [RADDR_W-1:0] result_dest;
	logic [XLEN-1:0]    result_data;
	logic               illegal;
	logic               dump_valid;
	logic [RADDR_W-1:0] dump_index;
	logic [XLEN-1:0]    dump_word;

	// Stimulus word and {illegal, dest, value} per row
	logic [XLEN-1:0]       row_instr [32];
	logic [XLEN+RADDR_W:0] row_exp [32];
	int                    n_rows = 0;
	int                    repeat_rows;
	int                    wait_cnt;

	regexec_top uut (.*);
	regexec_monitor mon (.*);
	bind regexec_top regexec_chk u_chk (.*);

	function automatic logic [XLEN-1:0] i_word(input logic [5:0] op, input int rs,
		input int rt, input logic [15:0] imm);
		return {op, RADDR_W'(rs), RADDR_W'(rt), imm};
	endfunction

	function automatic logic [XLEN-1:0] r_word(input int rs, input int rt, input int rd,
		input int sh, input logic [5:0] fn);
		return {OP_RTYPE, RADDR_W'(rs), RADDR_W'(rt), RADDR_W'(rd), RADDR_W'(sh), fn};
	endfunction

	task automatic add_row(input logic [XLEN-1:0] w, input int ill, input int d,
		input logic [XLEN-1:0] v);
		row_instr[n_rows] = w;
		row_exp[n_rows]   = {1'(ill), RADDR_W'(d), v};
		n_rows++;
	endtask

	// Issue one row, then idle for gap cycles
	task automatic apply_row(input int idx, input int gap);
		@(posedge clk);
		instr       <= row_instr[idx];
		instr_valid <= 1'b1;
		mon.queue_result(row_exp[idx]);
		repeat (gap)
		begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		void'($urandom(32'ha35c_fccc));
		rst         = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		dump_req    = 1'b0;

		//////////////////////////////////////////////////////////////////////
		// Stimulus table
		//////////////////////////////////////////////////////////////////////

		add_row(i_word(OP_ADDI, 0, 1, 16'h0005), 0, 1, 32'h0000_0005);
		add_row(i_word(OP_ADDI, 0, 2, 16'hfffd), 0, 2, 32'hffff_fffd);
		add_row(i_word(OP_ORI, 0, 3, 16'hf0f0), 0, 3, 32'h0000_f0f0);
		add_row(i_word(OP_LUI, 0, 4, 16'h1234), 0, 4, 32'h1234_0000);
		add_row(i_word(OP_ORI, 4, 4, 16'h5678), 0, 4, 32'h1234_5678);
		add_row(r_word(1, 2, 5, 0, FN_ADD), 0, 5, 32'h0000_0002);
		add_row(r_word(2, 1, 6, 0, FN_SUB), 0, 6, 32'hffff_fff8);
		add_row(r_word(4, 3, 7, 0, FN_AND), 0, 7, 32'h0000_5070);
		add_row(r_word(4, 3, 8, 0, FN_OR), 0, 8, 32'h1234_f6f8);
		add_row(r_word(4, 3, 9, 0, FN_XOR), 0, 9, 32'h1234_a688);
		add_row(r_word(1, 2, 10, 0, FN_NOR), 0, 10, 32'h0000_0002);
		add_row(r_word(2, 1, 11, 0, FN_SLT), 0, 11, 32'h0000_0001);
		add_row(r_word(1, 2, 12, 0, FN_SLT), 0, 12, 32'h0000_0000);
		add_row(r_word(0, 1, 13, 4, FN_SLL), 0, 13, 32'h0000_0050);
		add_row(r_word(0, 6, 14, 28, FN_SRL), 0, 14, 32'h0000_000f);
		// Each reads the row just before it
		add_row(r_word(14, 14, 15, 0, FN_ADD), 0, 15, 32'h0000_001e);
		add_row(r_word(15, 13, 16, 0, FN_SUB), 0, 16, 32'hffff_ffce);
		repeat_rows = n_rows;
		// Register 0 reports its result but keeps zero
		add_row(i_word(OP_ADDI, 1, 0, 16'h0064), 0, 0, 32'h0000_0069);
		add_row(r_word(0, 1, 17, 0, FN_ADD), 0, 17, 32'h0000_0005);
		// Undefined opcode and function code aimed at r3
		add_row(i_word(6'h3f, 0, 3, 16'h1111), 1, 0, 32'h0000_0000);
		add_row(r_word(1, 1, 3, 0, 6'h3f), 1, 0, 32'h0000_0000);
		add_row(r_word(3, 0, 18, 0, FN_OR), 0, 18, 32'h0000_f0f0);

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_rows; i++)
			apply_row(i, 0);
		// First two sections again with random idle gaps
		for (int i = 0; i < repeat_rows; i++)
			apply_row(i, $urandom_range(3, 0));
		@(posedge clk);
		instr_valid <= 1'b0;

		wait_cnt = 0;
		while (mon.pending != 0 && wait_cnt < 100)
		begin
			@(posedge clk);
			wait_cnt++;
		end
		if (mon.pending != 0)
		begin
			$display("Timed out waiting for %0d outstanding results", mon.pending);
			$display("TEST RESULT: FAIL");
			$finish;
		end

		// Dump, with a second request while it runs
		@(posedge clk);
		dump_req <= 1'b1;
		@(posedge clk);
		dump_req <= 1'b0;
		repeat (8) @(posedge clk);
		dump_req <= 1'b1;
		@(posedge clk);
		dump_req <= 1'b0;
		wait_cnt = 0;
		while (mon.dump_count < NREGS && wait_cnt < 100)
		begin
			@(posedge clk);
			wait_cnt++;
		end
		if (mon.dump_count < NREGS)
		begin
			$display("Timed out with only %0d dump words received", mon.dump_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
		repeat (4) @(posedge clk);

		$display("Dump words %0d, mismatches %0d, other errors %0d, assertion failures %0d",
			mon.dump_count, mon.mismatches, mon.errors, uut.u_chk.fail_count);
		if (mon.mismatches == 0 && mon.errors == 0 && uut.u_chk.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== regexec.f ====
verilog/regexec_pkg.sv
verilog/instr_decode.sv
verilog/reg_bank.sv
verilog/alu.sv
verilog/reg_dump.sv
verilog/regexec_top.sv
test/regexec_chk.sv
test/regexec_monitor.sv
test/regexec_tb.sv

// ==== Bender.yml ====
package:
  name: regexec

sources:
  - verilog/regexec_pkg.sv
  - verilog/instr_decode.sv
  - verilog/reg_bank.sv
  - verilog/alu.sv
  - verilog/reg_dump.sv
  - verilog/regexec_top.sv
  - target: test
    files:
      - test/regexec_chk.sv
      - test/regexec_monitor.sv
      - test/regexec_tb.sv
